/* hw/adam_ctrl_pkg.sv */
package adam_ctrl_pkg;

        // ============================================================
        // Sizes and key codes
        // ============================================================

        localparam int num_ports = 2;

        typedef logic [3:0] key_code_t;

        // Codes the console reads on the four key lines
        localparam key_code_t key_0_c      = 4'b0011;
        localparam key_code_t key_1_c      = 4'b1110;
        localparam key_code_t key_2_c      = 4'b1101;
        localparam key_code_t key_3_c      = 4'b0110;
        localparam key_code_t key_4_c      = 4'b0001;
        localparam key_code_t key_5_c      = 4'b1001;
        localparam key_code_t key_6_c      = 4'b0111;
        localparam key_code_t key_7_c      = 4'b1100;
        localparam key_code_t key_8_c      = 4'b1000;
        localparam key_code_t key_9_c      = 4'b1011;
        localparam key_code_t key_star_c   = 4'b1010;
        localparam key_code_t key_number_c = 4'b0101;
        localparam key_code_t key_purple_c = 4'b0100;
        localparam key_code_t key_blue_c   = 4'b0010;
        localparam key_code_t key_none_c   = 4'b1111;

        // ============================================================
        // PS/2 set 2 scan codes
        // ============================================================

        // Top row digits
        localparam logic [7:0] sc_row_0 = 8'h45;
        localparam logic [7:0] sc_row_1 = 8'h16;
        localparam logic [7:0] sc_row_2 = 8'h1E;
        localparam logic [7:0] sc_row_3 = 8'h26;
        localparam logic [7:0] sc_row_4 = 8'h25;
        localparam logic [7:0] sc_row_5 = 8'h2E;
        localparam logic [7:0] sc_row_6 = 8'h36;
        localparam logic [7:0] sc_row_7 = 8'h3D;
        localparam logic [7:0] sc_row_8 = 8'h3E;
        localparam logic [7:0] sc_row_9 = 8'h46;

        // Numeric pad digits
        localparam logic [7:0] sc_pad_0 = 8'h70;
        localparam logic [7:0] sc_pad_1 = 8'h69;
        localparam logic [7:0] sc_pad_2 = 8'h72;
        localparam logic [7:0] sc_pad_3 = 8'h7A;
        localparam logic [7:0] sc_pad_4 = 8'h6B;
        localparam logic [7:0] sc_pad_5 = 8'h73;
        localparam logic [7:0] sc_pad_6 = 8'h74;
        localparam logic [7:0] sc_pad_7 = 8'h6C;
        localparam logic [7:0] sc_pad_8 = 8'h75;
        localparam logic [7:0] sc_pad_9 = 8'h7D;

        localparam logic [7:0] sc_pad_star  = 8'h7C;
        localparam logic [7:0] sc_pad_minus = 8'h7B;
        localparam logic [7:0] sc_lshift    = 8'h12;
        localparam logic [7:0] sc_rshift    = 8'h59;

        // ============================================================
        // Structs
        // ============================================================

        // New event whenever toggle flips
        typedef struct packed {
                logic       toggle;
                logic       pressed;
                logic       extended;
                logic [7:0] code;
        } ps2_event_t;

        // Priority order, digit[0] is key 0; dir is {up, down, left, right}
        typedef struct packed {
                logic [9:0] digit;
                logic       star;
                logic       number;
                logic       purple;
                logic       blue;
                logic [3:0] dir;
                logic       fire1;
                logic       fire2;
        } keypad_t;

        typedef struct packed {
                logic [9:0] digit;
                logic       star;
                logic       minus;
                logic       shift;
        } kbd_buttons_t;

        // Active low, idle all ones
        typedef struct packed {
                key_code_t key_lines;
                logic      fire_n;
        } port_lines_t;

endpackage

/* hw/ps2_keypad.sv */
`timescale 1ns/1ps

module ps2_keypad (
        input  logic                        clk_sys,
        input  logic                        rst_i,
        input  adam_ctrl_pkg::ps2_event_t   ps2_key_i,
        output adam_ctrl_pkg::kbd_buttons_t buttons_o
);

        // ============================================================
        // Digit scan code tables, index is the digit
        // ============================================================

        localparam logic [9:0][7:0] row_sc = {
                adam_ctrl_pkg::sc_row_9, adam_ctrl_pkg::sc_row_8,
                adam_ctrl_pkg::sc_row_7, adam_ctrl_pkg::sc_row_6,
                adam_ctrl_pkg::sc_row_5, adam_ctrl_pkg::sc_row_4,
                adam_ctrl_pkg::sc_row_3, adam_ctrl_pkg::sc_row_2,
                adam_ctrl_pkg::sc_row_1, adam_ctrl_pkg::sc_row_0
        };

        localparam logic [9:0][7:0] pad_sc = {
                adam_ctrl_pkg::sc_pad_9, adam_ctrl_pkg::sc_pad_8,
                adam_ctrl_pkg::sc_pad_7, adam_ctrl_pkg::sc_pad_6,
                adam_ctrl_pkg::sc_pad_5, adam_ctrl_pkg::sc_pad_4,
                adam_ctrl_pkg::sc_pad_3, adam_ctrl_pkg::sc_pad_2,
                adam_ctrl_pkg::sc_pad_1, adam_ctrl_pkg::sc_pad_0
        };

        logic                        toggle_q;
        logic                        new_event;
        adam_ctrl_pkg::kbd_buttons_t buttons_q;
        adam_ctrl_pkg::kbd_buttons_t buttons_d;

        // Toggle flip marks a fresh event
        assign new_event = ps2_key_i.toggle != toggle_q;

        // ============================================================
        // Held button update
        // ============================================================

        // Extended flag plays no part, E0-prefixed keys match too
        always_comb begin
                buttons_d = buttons_q;
                if (new_event) begin
                        for (int i = 0; i < 10; i++) begin
                                if (ps2_key_i.code == row_sc[i] ||
                                    ps2_key_i.code == pad_sc[i]) begin
                                        buttons_d.digit[i] = ps2_key_i.pressed;
                                end
                        end

                        if (ps2_key_i.code == adam_ctrl_pkg::sc_pad_star) begin
                                buttons_d.star = ps2_key_i.pressed;
                        end

                        if (ps2_key_i.code == adam_ctrl_pkg::sc_pad_minus) begin
                                buttons_d.minus = ps2_key_i.pressed;
                        end

                        // Either shift key drives the one shift state
                        if (ps2_key_i.code == adam_ctrl_pkg::sc_lshift ||
                            ps2_key_i.code == adam_ctrl_pkg::sc_rshift) begin
                                buttons_d.shift = ps2_key_i.pressed;
                        end
                end
        end

        always_ff @(posedge clk_sys) begin
                if (rst_i) begin
                        toggle_q  <= 1'b0;
                        buttons_q <= '0;
                end else begin
                        toggle_q  <= ps2_key_i.toggle;
                        buttons_q <= buttons_d;
                end
        end

        assign buttons_o = buttons_q;

        // All keys released once reset has been seen
        a_released_after_reset: assert property (
                @(posedge clk_sys) rst_i |=> (buttons_o == '0)
        ) else $error("ps2_keypad: buttons held after reset");

endmodule

/* hw/keypad_merge.sv */
`timescale 1ns/1ps

module keypad_merge (
        input  logic [31:0]                                         joy0_i,
        input  logic [31:0]                                         joy1_i,
        input  logic                                                swap_i,
        input  adam_ctrl_pkg::kbd_buttons_t                         buttons_i,
        output adam_ctrl_pkg::keypad_t [adam_ctrl_pkg::num_ports-1:0] keypads_o
);

        logic [adam_ctrl_pkg::num_ports-1:0][31:0] joy_port;
        adam_ctrl_pkg::keypad_t                    kbd_kp;

        // ============================================================
        // MiSTer joystick word to keypad order
        // ============================================================

        // Joystick bits
        //   0 right, 1 left, 2 down, 3 up, 4 fire1, 5 fire2
        //   6 star, 7 number, 8..17 digits 0..9, 18 purple, 19 blue
        function automatic adam_ctrl_pkg::keypad_t map_joy(input logic [31:0] joy);
                adam_ctrl_pkg::keypad_t kp;
                kp.digit  = joy[17:8];
                kp.star   = joy[6];
                kp.number = joy[7];
                kp.purple = joy[18];
                kp.blue   = joy[19];
                // Low nibble is already up, down, left, right
                kp.dir    = joy[3:0];
                kp.fire1  = joy[4];
                kp.fire2  = joy[5];
                return kp;
        endfunction

        // Joystick swap
        assign joy_port[0] = swap_i ? joy1_i : joy0_i;
        assign joy_port[1] = swap_i ? joy0_i : joy1_i;

        // ============================================================
        // Keyboard contribution, shared by both ports
        // ============================================================

        always_comb begin
                kbd_kp        = '0;
                kbd_kp.digit  = buttons_i.digit;
                // Shift-8 gives star
                kbd_kp.star   = buttons_i.star | (buttons_i.shift & buttons_i.digit[8]);
                // Keypad minus or shift-3 gives number
                kbd_kp.number = buttons_i.minus | (buttons_i.shift & buttons_i.digit[3]);
        end

        always_comb begin
                for (int p = 0; p < adam_ctrl_pkg::num_ports; p++) begin
                        keypads_o[p] = map_joy(joy_port[p]) | kbd_kp;
                end
        end

endmodule

/* hw/port_encoder.sv */
`timescale 1ns/1ps

module port_encoder (
        input  adam_ctrl_pkg::keypad_t     keypad_i,
        input  logic                       keypad_sel_n_i,
        input  logic                       joy_sel_n_i,
        output adam_ctrl_pkg::port_lines_t lines_o
);

        // Code per keypad bit, index 0 has top priority
        localparam adam_ctrl_pkg::key_code_t [13:0] code_table = {
                adam_ctrl_pkg::key_blue_c,
                adam_ctrl_pkg::key_purple_c,
                adam_ctrl_pkg::key_number_c,
                adam_ctrl_pkg::key_star_c,
                adam_ctrl_pkg::key_9_c,
                adam_ctrl_pkg::key_8_c,
                adam_ctrl_pkg::key_7_c,
                adam_ctrl_pkg::key_6_c,
                adam_ctrl_pkg::key_5_c,
                adam_ctrl_pkg::key_4_c,
                adam_ctrl_pkg::key_3_c,
                adam_ctrl_pkg::key_2_c,
                adam_ctrl_pkg::key_1_c,
                adam_ctrl_pkg::key_0_c
        };

        logic [13:0]                keys;
        adam_ctrl_pkg::key_code_t   key_code;
        adam_ctrl_pkg::port_lines_t keypad_half;
        adam_ctrl_pkg::port_lines_t joy_half;

        assign keys = {keypad_i.blue, keypad_i.purple, keypad_i.number,
                       keypad_i.star, keypad_i.digit};

        // ============================================================
        // Keypad half
        // ============================================================

        // Scan from the bottom of the priority list up, lowest index wins
        always_comb begin
                key_code = adam_ctrl_pkg::key_none_c;
                for (int i = 13; i >= 0; i--) begin
                        if (keys[i]) begin
                                key_code = code_table[i];
                        end
                end
        end

        assign keypad_half.key_lines = keypad_sel_n_i ? adam_ctrl_pkg::key_none_c : key_code;
        assign keypad_half.fire_n    = keypad_sel_n_i | ~keypad_i.fire2;

        // ============================================================
        // Joystick half
        // ============================================================

        assign joy_half.key_lines = joy_sel_n_i ? adam_ctrl_pkg::key_none_c : ~keypad_i.dir;
        assign joy_half.fire_n    = joy_sel_n_i | ~keypad_i.fire1;

        // Open-collector style merge of both strobes
        assign lines_o = keypad_half & joy_half;

        // Idle port reads all ones, whatever the pad state
        always_comb begin
                if (keypad_sel_n_i && joy_sel_n_i) begin
                        a_idle_all_ones: assert (lines_o == '1)
                        else $error("port_encoder: lines not idle with both selects high");
                end
        end

endmodule

/* hw/adam_ctrl_top.sv */
`timescale 1ns/1ps

module adam_ctrl_top (
        input  logic                                                    clk_sys,
        input  logic                                                    rst_i,
        input  adam_ctrl_pkg::ps2_event_t                               ps2_key_i,
        input  logic [31:0]                                             joy0_i,
        input  logic [31:0]                                             joy1_i,
        input  logic                                                    swap_i,
        input  logic [adam_ctrl_pkg::num_ports-1:0]                     keypad_sel_n_i,
        input  logic [adam_ctrl_pkg::num_ports-1:0]                     joy_sel_n_i,
        output adam_ctrl_pkg::port_lines_t [adam_ctrl_pkg::num_ports-1:0] port_lines_o
);

        adam_ctrl_pkg::kbd_buttons_t                               kbd_buttons;
        adam_ctrl_pkg::keypad_t [adam_ctrl_pkg::num_ports-1:0]     keypads;

        // ============================================================
        // Keyboard and joystick merge
        // ============================================================

        ps2_keypad ps2_keypad_inst (
                .clk_sys   (clk_sys),
                .rst_i     (rst_i),
                .ps2_key_i (ps2_key_i),
                .buttons_o (kbd_buttons)
        );

        keypad_merge keypad_merge_inst (
                .joy0_i    (joy0_i),
                .joy1_i    (joy1_i),
                .swap_i    (swap_i),
                .buttons_i (kbd_buttons),
                .keypads_o (keypads)
        );

        // ============================================================
        // One encoder per controller port
        // ============================================================

        // Each port answers its own select strobes
        for (genvar p = 0; p < adam_ctrl_pkg::num_ports; p++) begin : g_port
                port_encoder port_encoder_inst (
                        .keypad_i       (keypads[p]),
                        .keypad_sel_n_i (keypad_sel_n_i[p]),
                        .joy_sel_n_i    (joy_sel_n_i[p]),
                        .lines_o        (port_lines_o[p])
                );
        end

endmodule

/* dv/ctrl_checker.sv */
`timescale 1ns/1ps

module ctrl_checker (
        input  logic                                              clk_sys,
        input  logic                                              rst_i,
        input  adam_ctrl_pkg::ps2_event_t                         ps2_key_i,
        input  logic [31:0]                                       joy0_i,
        input  logic [31:0]                                       joy1_i,
        input  logic                                              swap_i,
        input  logic [adam_ctrl_pkg::num_ports-1:0]               keypad_sel_n_i,
        input  logic [adam_ctrl_pkg::num_ports-1:0]               joy_sel_n_i,
        input  adam_ctrl_pkg::port_lines_t [adam_ctrl_pkg::num_ports-1:0] port_lines_i,
        output int                                                error_count_o,
        output int                                                check_count_o
);

        // Held keys: digits 9..0, then star 10, minus 11, shift 12
        logic [12:0] btn_q;
        logic        toggle_q;
        int          errors = 0;
        int          checks = 0;

        assign error_count_o = errors;
        assign check_count_o = checks;

        // ============================================================
        // Reference model
        // ============================================================

        function automatic logic [12:0] apply_event(input logic [12:0] btn,
                                                    input logic [7:0]  code,
                                                    input logic        pressed);
                logic [12:0] b;
                b = btn;
                case (code)
                8'h45, 8'h70: b[0] = pressed;
                8'h16, 8'h69: b[1] = pressed;
                8'h1E, 8'h72: b[2] = pressed;
                8'h26, 8'h7A: b[3] = pressed;
                8'h25, 8'h6B: b[4] = pressed;
                8'h2E, 8'h73: b[5] = pressed;
                8'h36, 8'h74: b[6] = pressed;
                8'h3D, 8'h6C: b[7] = pressed;
                8'h3E, 8'h75: b[8] = pressed;
                8'h46, 8'h7D: b[9] = pressed;
                8'h7C: b[10] = pressed;
                8'h7B: b[11] = pressed;
                8'h12, 8'h59: b[12] = pressed;
                default: b = btn;
                endcase
                return b;
        endfunction

        function automatic logic [3:0] digit_code(input int d);
                case (d)
                0: return 4'b0011;
                1: return 4'b1110;
                2: return 4'b1101;
                3: return 4'b0110;
                4: return 4'b0001;
                5: return 4'b1001;
                6: return 4'b0111;
                7: return 4'b1100;
                8: return 4'b1000;
                9: return 4'b1011;
                default: return 4'b1111;
                endcase
        endfunction

        // Returns {key lines, fire_n} for one port
        function automatic logic [4:0] expected_lines(input logic [31:0] joy,
                                                      input logic [12:0] btn,
                                                      input logic        ks_n,
                                                      input logic        js_n);
                logic [9:0] digit;
                logic       star;
                logic       number;
                logic       found;
                logic [3:0] code;
                logic [4:0] kp_half;
                logic [4:0] joy_half;
                digit  = joy[17:8] | btn[9:0];
                star   = joy[6] | btn[10] | (btn[12] & btn[8]);
                number = joy[7] | btn[11] | (btn[12] & btn[3]);
                code   = 4'b1111;
                found  = 1'b0;
                for (int i = 0; i < 10; i++) begin
                        if (!found && digit[i]) begin
                                code  = digit_code(i);
                                found = 1'b1;
                        end
                end
                if (!found && star) begin
                        code  = 4'b1010;
                        found = 1'b1;
                end
                if (!found && number) begin
                        code  = 4'b0101;
                        found = 1'b1;
                end
                if (!found && joy[18]) begin
                        code  = 4'b0100;
                        found = 1'b1;
                end
                if (!found && joy[19]) begin
                        code = 4'b0010;
                end
                kp_half  = ks_n ? 5'b11111 : {code, ~joy[5]};
                // Directions up, down, left, right sit in joy[3:0]
                joy_half = js_n ? 5'b11111 : {~joy[3:0], ~joy[4]};
                return kp_half & joy_half;
        endfunction

        always @(posedge clk_sys) begin
                if (rst_i) begin
                        btn_q    <= '0;
                        toggle_q <= 1'b0;
                end else begin
                        toggle_q <= ps2_key_i.toggle;
                        if (ps2_key_i.toggle != toggle_q) begin
                                btn_q <= apply_event(btn_q, ps2_key_i.code, ps2_key_i.pressed);
                        end
                end
        end

        // ============================================================
        // Comparison in the middle of each cycle
        // ============================================================

        always @(negedge clk_sys) begin : compare_ports
                logic [31:0] joy;
                logic [4:0]  exp_lines;
                if (!rst_i) begin
                        for (int p = 0; p < adam_ctrl_pkg::num_ports; p++) begin
                                if (p == 0) begin
                                        joy = swap_i ? joy1_i : joy0_i;
                                end else begin
                                        joy = swap_i ? joy0_i : joy1_i;
                                end
                                exp_lines = expected_lines(joy, btn_q, keypad_sel_n_i[p],
                                                           joy_sel_n_i[p]);
                                checks = checks + 1;
                                if (port_lines_i[p] !== exp_lines) begin
                                        errors = errors + 1;
                                        $display("MISMATCH port_lines_o[%0d] at %0t: expected %h, got %h",
                                                 p, $time, exp_lines, port_lines_i[p]);
                                end
                        end
                end
        end

endmodule

/* dv/tb_adam_ctrl.sv */
`timescale 1ns/1ps

module tb_adam_ctrl;

        // ============================================================
        // Run length
        // ============================================================

        localparam int num_phases   = 4;
        localparam int phase_cycles = 400;
        localparam int reset_cycles = 16;
        // Two resets and four phases need about 1640 cycles
        localparam int timeout_cycles = 2000;

        logic                                              clk_sys;
        logic                                              rst;
        adam_ctrl_pkg::ps2_event_t                         ps2_key;
        logic [31:0]                                       joy0;
        logic [31:0]                                       joy1;
        logic                                              swap;
        logic [adam_ctrl_pkg::num_ports-1:0]               keypad_sel_n;
        logic [adam_ctrl_pkg::num_ports-1:0]               joy_sel_n;
        adam_ctrl_pkg::port_lines_t [adam_ctrl_pkg::num_ports-1:0] port_lines;

        integer seed = 32'h46be_a0e3;
        int     ev_gap = 0;
        int     cycle_count = 0;
        int     error_count;
        int     check_count;

        adam_ctrl_top adam_ctrl_top_inst (
                .clk_sys        (clk_sys),
                .rst_i          (rst),
                .ps2_key_i      (ps2_key),
                .joy0_i         (joy0),
                .joy1_i         (joy1),
                .swap_i         (swap),
                .keypad_sel_n_i (keypad_sel_n),
                .joy_sel_n_i    (joy_sel_n),
                .port_lines_o   (port_lines)
        );

        ctrl_checker ctrl_checker_inst (
                .clk_sys        (clk_sys),
                .rst_i          (rst),
                .ps2_key_i      (ps2_key),
                .joy0_i         (joy0),
                .joy1_i         (joy1),
                .swap_i         (swap),
                .keypad_sel_n_i (keypad_sel_n),
                .joy_sel_n_i    (joy_sel_n),
                .port_lines_i   (port_lines),
                .error_count_o  (error_count),
                .check_count_o  (check_count)
        );

        initial begin
                clk_sys = 1'b0;
                forever #2 clk_sys = ~clk_sys;
        end

        // ============================================================
        // Stimulus helpers
        // ============================================================

        // Table codes from both digit rows, star, minus and both shifts
        function automatic logic [7:0] pick_code();
                logic [7:0]  codes [0:23];
                logic [31:0] r;
                codes = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D,
                          8'h3E, 8'h46, 8'h70, 8'h69, 8'h72, 8'h7A, 8'h6B, 8'h73,
                          8'h74, 8'h6C, 8'h75, 8'h7D, 8'h7C, 8'h7B, 8'h12, 8'h59};
                r = $random(seed);
                if (r[4:0] < 5'd24) begin
                        return codes[r[4:0]];
                end
                // Mostly codes the keypad ignores
                return r[15:8];
        endfunction

        // Few buttons held at once so lower priorities show up too
        function automatic logic [31:0] sparse_word();
                logic [31:0] a;
                logic [31:0] b;
                logic [31:0] c;
                a = $random(seed);
                b = $random(seed);
                c = $random(seed);
                return a & b & c;
        endfunction

        task automatic drive_inputs(input int phase);
                logic [31:0]               r;
                adam_ctrl_pkg::ps2_event_t ev;
                r = $random(seed);
                case (phase)
                0: begin
                        // Idle strobes, dense joystick words
                        keypad_sel_n <= 2'b11;
                        joy_sel_n    <= 2'b11;
                        joy0         <= $random(seed);
                        joy1         <= $random(seed);
                end
                1: begin
                        keypad_sel_n <= 2'b00;
                        joy_sel_n    <= 2'b11;
                        joy0         <= sparse_word();
                        joy1         <= sparse_word();
                end
                2: begin
                        keypad_sel_n <= r[1:0];
                        joy_sel_n    <= 2'b00;
                        joy0         <= sparse_word();
                        joy1         <= sparse_word();
                end
                default: begin
                        keypad_sel_n <= r[1:0];
                        joy_sel_n    <= r[3:2];
                        joy0         <= sparse_word();
                        joy1         <= sparse_word();
                end
                endcase
                swap <= r[8];

                // PS/2 event at most every third cycle
                if (ev_gap >= 2 && r[5:4] == 2'b00) begin
                        ev.toggle   = ~ps2_key.toggle;
                        ev.pressed  = r[6];
                        ev.extended = r[7];
                        ev.code     = pick_code();
                        ps2_key    <= ev;
                        ev_gap      = 0;
                end else begin
                        ev_gap = ev_gap + 1;
                end
        endtask

        task automatic apply_reset();
                rst <= 1'b1;
                repeat (reset_cycles) @(posedge clk_sys);
                rst <= 1'b0;
        endtask

        // ============================================================
        // Main sequence
        // ============================================================

        initial begin
                rst          = 1'b1;
                ps2_key      = '0;
                joy0         = '0;
                joy1         = '0;
                swap         = 1'b0;
                keypad_sel_n = '1;
                joy_sel_n    = '1;
                apply_reset();
                for (int phase = 0; phase < num_phases; phase++) begin
                        // Second reset while keys are held
                        if (phase == num_phases - 1) begin
                                apply_reset();
                        end
                        repeat (phase_cycles) begin
                                @(posedge clk_sys);
                                drive_inputs(phase);
                        end
                end
                @(negedge clk_sys);
                @(posedge clk_sys);
                $display("Checks: %0d, errors: %0d", check_count, error_count);
                if (error_count == 0 && check_count > 0) begin
                        $display("TEST PASSED");
                end else begin
                        if (check_count == 0) begin
                                $display("No port checks were made during the run");
                        end
                        $display("TEST FAILED");
                end
                $finish;
        end

        always @(posedge clk_sys) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= timeout_cycles) begin
                        $display("Timeout: run still going after %0d cycles", timeout_cycles);
                        $display("TEST FAILED");
                        $finish;
                end
        end

endmodule

/* adam_ctrl.f */
hw/adam_ctrl_pkg.sv
hw/ps2_keypad.sv
hw/keypad_merge.sv
hw/port_encoder.sv
hw/adam_ctrl_top.sv
dv/ctrl_checker.sv
dv/tb_adam_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --timing --assert
TOP       = tb_adam_ctrl
FILELIST  = adam_ctrl.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = TEST PASSED

.PHONY: all lint build sim clean

all: sim

# Static checks only
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJDIR) -o $(TOP)

# Pass or fail is decided by the log
sim: build
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
